/* verilog.f */
verilog/spi_pkg.sv
verilog/spi_cmd_fifo.sv
verilog/spi_cfg_regs.sv
verilog/spi_clk_gen.sv
verilog/spi_master_fsm.sv
verilog/spi_ctrl_top.sv
testbench/spi_ctrl_sva.sv
testbench/tb_spi_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_spi_ctrl
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_spi_ctrl.sv */
`timescale 1ns/1ps

module tb_spi_ctrl;
  import spi_pkg::*;

  localparam int DEPTH   = 4;
  localparam int TIMEOUT = 5000;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      cmd_vld;
  cmd_t      cmd_in;
  logic      cmd_credit;
  logic      cfg_wr;
  cfg_addr_t cfg_addr;
  cfg_data_t cfg_wdata;
  cfg_data_t cfg_rdata;
  logic      sclk;
  logic      cs;
  logic      mosi;
  logic      miso;
  logic      miso_next;
  logic      read_vld;
  rdata_t    read_data;

  logic [31:0] rng;
  int          credits;
  int          errors;
  int          timeouts;
  int          reads_sent;
  int          reads_seen;
  cmd_t        exp_cmds[$];

  // slave model state
  logic   prev_cs;
  logic   prev_sclk;
  logic   cur_cpol;
  int     cur_half;
  int     lead_cnt;
  int     level_len;
  bit     have_edge;
  cmd_t   cap_word;
  rdata_t slave_byte;

  spi_ctrl_top #(
    .FIFO_DEPTH (DEPTH)
  ) dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_vld    (cmd_vld),
    .cmd_in     (cmd_in),
    .cmd_credit (cmd_credit),
    .cfg_wr     (cfg_wr),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .miso       (miso),
    .read_vld   (read_vld),
    .read_data  (read_data)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic finish_run();
    $display("closing counts: %0d check errors, %0d assertion failures, %0d timeouts",
             errors, dut.u_sva.fail_cnt, timeouts);
    if (errors == 0 && timeouts == 0 && dut.u_sva.fail_cnt == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout while waiting for %s", what);
    finish_run();
  endtask

  task automatic wait_credit();
    int t;
    t = 0;
    while (credits == 0)
    begin
      @(posedge clk);
      #1;
      t++;
      if (t > TIMEOUT)
      begin
        report_timeout("a command credit");
      end
    end
  endtask

  task automatic send_cmd(input cmd_t c);
    wait_credit();
    cmd_vld = 1'b1;
    cmd_in  = c;
    credits--;
    exp_cmds.push_back(c);
    if (!c[WRITE_BIT])
    begin
      reads_sent++;
    end
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  function automatic cmd_t next_cmd(input bit is_write);
    cmd_t c;
    rng = xorshift(rng);
    c = rng[11:0];
    c[WRITE_BIT] = is_write;
    return c;
  endfunction

  task automatic wait_all_done();
    int t;
    t = 0;
    while (exp_cmds.size() != 0 || !cs)
    begin
      @(posedge clk);
      #1;
      t++;
      if (t > TIMEOUT)
      begin
        report_timeout("queued transfers to finish");
      end
    end
  endtask

  task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_wr = 1'b0;
  endtask

  task automatic cfg_check(input cfg_addr_t addr, input cfg_data_t exp);
    cfg_addr = addr;
    @(negedge clk);
    assert (cfg_rdata == exp)
    else
    begin
      errors++;
      $display("CHECK FAILED cfg_rdata addr %h expected %h got %h", addr, exp, cfg_rdata);
    end
    @(posedge clk);
    #1;
  endtask

  // miso changes shortly after the rising edge
  always @(posedge clk)
  begin
    #1;
    miso = miso_next;
  end

  // slave model and transfer checks, sampled mid-cycle
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (cmd_credit)
      begin
        credits++;
      end
      if (prev_cs && !cs)
      begin
        lead_cnt  = 0;
        cap_word  = '0;
        have_edge = 0;
        rng        = xorshift(rng);
        slave_byte = rng[7:0];
      end
      if (!cs && sclk !== prev_sclk)
      begin
        if (sclk != cur_cpol)
        begin
          if (lead_cnt < 12)
          begin
            cap_word = {cap_word[10:0], mosi};
          end
          lead_cnt++;
        end
        else if (lead_cnt >= 12 && lead_cnt < 20)
        begin
          miso_next = slave_byte[19 - lead_cnt];
        end
        if (have_edge)
        begin
          assert (level_len == cur_half)
          else
          begin
            errors++;
            $display("CHECK FAILED sclk level length expected %h got %h", cur_half, level_len);
          end
        end
        level_len = 1;
        have_edge = 1;
      end
      else if (!cs)
      begin
        level_len++;
      end
      if (!prev_cs && cs)
      begin
        if (exp_cmds.size() == 0)
        begin
          errors++;
          $display("a transfer ended with no command outstanding");
        end
        else
        begin
          cmd_t exp;
          exp = exp_cmds.pop_front();
          assert (cap_word == exp)
          else
          begin
            errors++;
            $display("CHECK FAILED mosi word expected %h got %h", exp, cap_word);
          end
          if (!exp[WRITE_BIT])
          begin
            assert (read_vld && read_data == slave_byte)
            else
            begin
              errors++;
              $display("CHECK FAILED read_data expected %h got %h (read_vld %h)",
                       slave_byte, read_data, read_vld);
            end
            reads_seen++;
          end
          else
          begin
            assert (!read_vld)
            else
            begin
              errors++;
              $display("CHECK FAILED read_vld expected %h got %h", 1'b0, read_vld);
            end
          end
        end
      end
      else if (read_vld)
      begin
        errors++;
        $display("read_vld pulsed outside the end of a read transfer");
      end
      prev_cs   = cs;
      prev_sclk = sclk;
    end
  end

  initial
  begin
    rst_n      = 1'b0;
    cmd_vld    = 1'b0;
    cmd_in     = '0;
    cfg_wr     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    miso       = 1'b0;
    miso_next  = 1'b0;
    rng        = 32'h159c;
    credits    = DEPTH;
    errors     = 0;
    timeouts   = 0;
    reads_sent = 0;
    reads_seen = 0;
    prev_cs    = 1'b1;
    prev_sclk  = 1'b0;
    cur_cpol   = 1'b0;
    cur_half   = int'(DIV_RESET) + 1;
    lead_cnt   = 0;
    level_len  = 0;
    have_edge  = 0;
    cap_word   = '0;
    slave_byte = '0;

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // idle state after reset
    repeat (5)
    begin
      @(negedge clk);
      assert (cs && !sclk && !mosi && !read_vld && !cmd_credit)
      else
      begin
        errors++;
        $display("CHECK FAILED idle outputs cs %h sclk %h mosi %h read_vld %h cmd_credit %h",
                 cs, sclk, mosi, read_vld, cmd_credit);
      end
    end
    @(posedge clk);
    #1;

    // single transfers
    send_cmd(next_cmd(1'b1));
    wait_all_done();
    send_cmd(next_cmd(1'b0));
    wait_all_done();
    send_cmd(next_cmd(1'b1));
    wait_all_done();
    send_cmd(next_cmd(1'b0));
    wait_all_done();

    // burst on four credits, then four more as credits return
    for (int i = 0; i < 8; i++)
    begin
      send_cmd(next_cmd(i[0]));
    end
    wait_all_done();

    // slower clock with inverted polarity
    cfg_write(CFG_ADDR_DIV, 8'd3);
    cfg_write(CFG_ADDR_MODE, 8'd1);
    cur_half = 4;
    cur_cpol = 1'b1;
    cfg_check(CFG_ADDR_DIV, 8'd3);
    cfg_check(CFG_ADDR_MODE, 8'd1);
    cfg_check(2'd2, 8'd0);
    assert (sclk == 1'b1)
    else
    begin
      errors++;
      $display("CHECK FAILED sclk idle expected %h got %h", 1'b1, sclk);
    end
    for (int i = 0; i < 4; i++)
    begin
      rng = xorshift(rng);
      send_cmd(next_cmd(rng[3]));
    end
    wait_all_done();

    repeat (10) @(posedge clk);
    assert (reads_seen == reads_sent && credits == DEPTH)
    else
    begin
      errors++;
      $display("CHECK FAILED reads seen %h of %h, credits %h", reads_seen, reads_sent, credits);
    end
    finish_run();
  end

endmodule

/* testbench/spi_ctrl_sva.sv */
`timescale 1ns/1ps

module spi_ctrl_sva
  import spi_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_credit,
  input logic fifo_pop,
  input cmd_t fifo_head,
  input logic cs,
  input logic sclk,
  input logic cpol,
  input logic mosi,
  input logic lead_edge,
  input logic trail_edge
);

  int       host_cred;
  int       accepted;
  int       returned;
  int       lead_cnt;
  logic     xfer_wr;
  // failed assertions, read by the testbench at the end
  int       fail_cnt = 0;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      host_cred <= FIFO_DEPTH;
      accepted  <= 0;
      returned  <= 0;
      lead_cnt  <= 0;
      xfer_wr   <= 1'b0;
    end
    else
    begin
      host_cred <= host_cred + int'(cmd_credit) - int'(cmd_vld);
      accepted  <= accepted + int'(cmd_vld);
      returned  <= returned + int'(cmd_credit);
      if (fifo_pop)
      begin
        lead_cnt <= 0;
        xfer_wr  <= fifo_head[WRITE_BIT];
      end
      else if (lead_edge)
      begin
        lead_cnt <= lead_cnt + 1;
      end
    end
  end

  // host may only send on a credit
  vld_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_vld |-> host_cred > 0)
    else
    begin
      fail_cnt++;
      $error("cmd_vld without a credit");
    end

  credit_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_credit |-> returned < accepted)
    else
    begin
      fail_cnt++;
      $error("cmd_credit beyond accepted commands");
    end

  edge_count: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cs) |-> lead_cnt == (xfer_wr ? 12 : 20))
    else
    begin
      fail_cnt++;
      $error("wrong number of leading edges in a transfer");
    end

  sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cs |-> sclk == cpol)
    else
    begin
      fail_cnt++;
      $error("sclk not at idle level while cs high");
    end

  mosi_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (!cs && !$past(cs) && !$past(trail_edge)) |-> $stable(mosi))
    else
    begin
      fail_cnt++;
      $error("mosi changed away from a trailing edge");
    end

endmodule

bind spi_ctrl_top spi_ctrl_sva #(
  .FIFO_DEPTH (FIFO_DEPTH)
) u_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .cmd_vld    (cmd_vld),
  .cmd_credit (cmd_credit),
  .fifo_pop   (fifo_pop),
  .fifo_head  (fifo_head),
  .cs         (cs),
  .sclk       (sclk),
  .cpol       (cpol),
  .mosi       (mosi),
  .lead_edge  (lead_edge),
  .trail_edge (trail_edge)
);

/* verilog/spi_ctrl_top.sv */
`timescale 1ns/1ps

module spi_ctrl_top
  import spi_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cmd_vld,
  input  cmd_t      cmd_in,
  output logic      cmd_credit,
  input  logic      cfg_wr,
  input  cfg_addr_t cfg_addr,
  input  cfg_data_t cfg_wdata,
  output cfg_data_t cfg_rdata,
  output logic      sclk,
  output logic      cs,
  output logic      mosi,
  input  logic      miso,
  output logic      read_vld,
  output rdata_t    read_data
);

  logic fifo_empty;
  cmd_t fifo_head;
  logic fifo_pop;
  div_t clk_div;
  logic cpol;
  logic sclk_run;
  logic lead_edge;
  logic trail_edge;

  spi_cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_vld    (cmd_vld),
    .cmd_in     (cmd_in),
    .fifo_pop   (fifo_pop),
    .fifo_head  (fifo_head),
    .fifo_empty (fifo_empty),
    .cmd_credit (cmd_credit)
  );

  spi_cfg_regs u_cfg_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .clk_div   (clk_div),
    .cpol      (cpol)
  );

  spi_clk_gen u_clk_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .sclk_run   (sclk_run),
    .clk_div    (clk_div),
    .cpol       (cpol),
    .sclk       (sclk),
    .lead_edge  (lead_edge),
    .trail_edge (trail_edge)
  );

  spi_master_fsm u_master_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_empty (fifo_empty),
    .fifo_head  (fifo_head),
    .fifo_pop   (fifo_pop),
    .sclk_run   (sclk_run),
    .lead_edge  (lead_edge),
    .trail_edge (trail_edge),
    .cs         (cs),
    .mosi       (mosi),
    .miso       (miso),
    .read_vld   (read_vld),
    .read_data  (read_data)
  );

endmodule

/* verilog/spi_master_fsm.sv */
`timescale 1ns/1ps

module spi_master_fsm
  import spi_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   fifo_empty,
  input  cmd_t   fifo_head,
  output logic   fifo_pop,
  output logic   sclk_run,
  input  logic   lead_edge,
  input  logic   trail_edge,
  output logic   cs,
  output logic   mosi,
  input  logic   miso,
  output logic   read_vld,
  output rdata_t read_data
);

  spi_state_e state;
  spi_state_e state_nxt;
  cmd_t       tx_sr;
  rdata_t     rx_sr;
  bit_cnt_t   bit_cnt;
  logic       is_write;
  div_t       hp_cnt;
  div_t       hp_len;
  logic       cs_q;
  logic       read_vld_q;
  logic       cmd_done;
  logic       read_done;
  logic       finish_done;

  assign cmd_done    = (state == SHIFT_CMD) && trail_edge && (bit_cnt == CMD_BITS);
  assign read_done   = (state == SHIFT_READ) && trail_edge && (bit_cnt == READ_BITS);
  // closing half period measured against the last sclk half period
  assign finish_done = (state == FINISH) && (hp_cnt == hp_len);

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (!fifo_empty)
        begin
          state_nxt = LOAD;
        end
      end
      LOAD:
      begin
        state_nxt = SHIFT_CMD;
      end
      SHIFT_CMD:
      begin
        if (cmd_done)
        begin
          state_nxt = is_write ? FINISH : SHIFT_READ;
        end
      end
      SHIFT_READ:
      begin
        if (read_done)
        begin
          state_nxt = FINISH;
        end
      end
      FINISH:
      begin
        if (finish_done)
        begin
          state_nxt = IDLE;
        end
      end
      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= IDLE;
      cs_q       <= 1'b1;
      read_vld_q <= 1'b0;
      bit_cnt    <= '0;
      hp_cnt     <= '0;
      tx_sr      <= '0;
      is_write   <= 1'b0;
    end
    else
    begin
      state      <= state_nxt;
      read_vld_q <= finish_done && !is_write;

      if (state == LOAD)
      begin
        cs_q <= 1'b0;
      end
      else if (finish_done)
      begin
        cs_q <= 1'b1;
      end

      // leading edges counted per phase
      if ((state == LOAD) || cmd_done)
      begin
        bit_cnt <= '0;
      end
      else if (lead_edge)
      begin
        bit_cnt <= bit_cnt + 1'b1;
      end

      // runs in step with the divider counter
      if (lead_edge || trail_edge || (state == LOAD))
      begin
        hp_cnt <= '0;
      end
      else
      begin
        hp_cnt <= hp_cnt + 1'b1;
      end

      if (state == LOAD)
      begin
        tx_sr    <= fifo_head;
        is_write <= fifo_head[WRITE_BIT];
      end
      else if (trail_edge)
      begin
        tx_sr <= {tx_sr[CMD_W-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (trail_edge)
    begin
      hp_len <= hp_cnt;
    end
    if (lead_edge && (state == SHIFT_READ))
    begin
      rx_sr <= {rx_sr[RDATA_W-2:0], miso};
    end
  end

  assign fifo_pop  = (state == LOAD);
  assign sclk_run  = (state == SHIFT_CMD) || (state == SHIFT_READ);
  assign cs        = cs_q;
  assign mosi      = tx_sr[CMD_W-1];
  assign read_vld  = read_vld_q;
  assign read_data = rx_sr;

endmodule

/* verilog/spi_clk_gen.sv */
`timescale 1ns/1ps

module spi_clk_gen
  import spi_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic sclk_run,
  input  div_t clk_div,
  input  logic cpol,
  output logic sclk,
  output logic lead_edge,
  output logic trail_edge
);

  div_t cnt;
  logic phase;
  logic toggle;

  // half period is clk_div+1 cycles
  assign toggle = sclk_run && (cnt == clk_div);

  // phase 0 means sclk sits at its idle level
  assign lead_edge  = toggle && !phase;
  assign trail_edge = toggle && phase;

  assign sclk = phase ^ cpol;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt   <= '0;
      phase <= 1'b0;
    end
    else if (!sclk_run)
    begin
      // restart cleanly so the first edge is a full half period out
      cnt   <= '0;
      phase <= 1'b0;
    end
    else if (toggle)
    begin
      cnt   <= '0;
      phase <= ~phase;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

/* verilog/spi_cfg_regs.sv */
`timescale 1ns/1ps

module spi_cfg_regs
  import spi_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cfg_wr,
  input  cfg_addr_t cfg_addr,
  input  cfg_data_t cfg_wdata,
  output cfg_data_t cfg_rdata,
  output div_t      clk_div,
  output logic      cpol
);

  div_t      div_q;
  cfg_data_t mode_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_q  <= DIV_RESET;
      mode_q <= '0;
    end
    else if (cfg_wr)
    begin
      case (cfg_addr)
        CFG_ADDR_DIV:  div_q <= cfg_wdata;
        // only the polarity bit is implemented
        CFG_ADDR_MODE: mode_q[MODE_CPOL_BIT] <= cfg_wdata[MODE_CPOL_BIT];
        default:       ;
      endcase
    end
  end

  always_comb
  begin
    case (cfg_addr)
      CFG_ADDR_DIV:  cfg_rdata = div_q;
      CFG_ADDR_MODE: cfg_rdata = mode_q;
      default:       cfg_rdata = '0;
    endcase
  end

  assign clk_div = div_q;
  assign cpol    = mode_q[MODE_CPOL_BIT];

endmodule

/* verilog/spi_cmd_fifo.sv */
`timescale 1ns/1ps

module spi_cmd_fifo
  import spi_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic cmd_vld,
  input  cmd_t cmd_in,
  input  logic fifo_pop,
  output cmd_t fifo_head,
  output logic fifo_empty,
  output logic cmd_credit
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  cmd_t             mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // a full queue drops the word, the host broke its credit contract
  assign push = cmd_vld && (count != CNT_W'(FIFO_DEPTH));
  assign pop  = fifo_pop && (count != '0);

  assign fifo_head  = mem[rd_ptr];
  assign fifo_empty = (count == '0);

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      cmd_credit <= 1'b0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // one credit back per entry taken
      cmd_credit <= pop;
    end
  end

endmodule

/* verilog/spi_pkg.sv */
package spi_pkg;

  // field widths
  localparam int CMD_W     = 12;
  localparam int RDATA_W   = 8;
  localparam int DIV_W     = 8;
  localparam int CFG_W     = 8;
  localparam int WRITE_BIT = 11;

  typedef logic [CMD_W-1:0]   cmd_t;
  typedef logic [RDATA_W-1:0] rdata_t;
  typedef logic [DIV_W-1:0]   div_t;
  typedef logic [1:0]         cfg_addr_t;
  typedef logic [CFG_W-1:0]   cfg_data_t;
  typedef logic [3:0]         bit_cnt_t;

  // leading edges per phase of a transfer
  localparam bit_cnt_t CMD_BITS  = 4'd12;
  localparam bit_cnt_t READ_BITS = 4'd8;

  // register map
  localparam cfg_addr_t CFG_ADDR_DIV  = 2'd0;
  localparam cfg_addr_t CFG_ADDR_MODE = 2'd1;

  // cpol position in the mode register
  localparam int MODE_CPOL_BIT = 0;

  localparam div_t DIV_RESET = 8'd1;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    SHIFT_CMD,
    SHIFT_READ,
    FINISH
  } spi_state_e;

endpackage
